/* verilog/umi_pkg.sv */
package umi_pkg;

   localparam int unsigned umi_cw = 32;                 // Command and data word width

   // Requests, low priority class
   localparam logic [4:0] umi_req_invalid = 5'd0;       // Dropped at ingress
   localparam logic [4:0] umi_req_read    = 5'd2;
   localparam logic [4:0] umi_req_write   = 5'd4;       // Write that wants an ack
   localparam logic [4:0] umi_req_atomic  = 5'd6;
   localparam logic [4:0] umi_req_link    = 5'd14;      // Link layer request

   // Posted writes and responses, high priority class
   localparam logic [4:0] umi_req_posted  = 5'd1;       // Store, no ack
   localparam logic [4:0] umi_resp_read   = 5'd3;       // Load data return
   localparam logic [4:0] umi_resp_write  = 5'd5;       // Write ack
   localparam logic [4:0] umi_resp_atomic = 5'd7;
   localparam logic [4:0] umi_resp_error  = 5'd15;
   localparam logic [4:0] umi_resp_link   = 5'd31;

   // Packet as it travels between stages
   typedef struct packed {
      logic [umi_cw-1:0] cmd;                          // Command word
      logic [umi_cw-1:0] data;                         // Single data beat
   } umi_pkt_t;

   // Command word split into fields
   typedef struct packed {
      logic [4:0]        opcode;                       // cmd[4:0]
      logic [2:0]        size;                         // cmd[7:5]
      logic [7:0]        len;                          // cmd[15:8]
      logic [1:0]        prot;                         // cmd[17:16]
      logic [3:0]        qos;                          // cmd[21:18]
      logic              eom;                          // cmd[22]
      logic              eof;                          // cmd[23]
      logic              ex;                           // cmd[24]
      logic [22:0]       user;                         // Layout set by command kind
      logic [7:0]        err;                          // cmd[23:22], zero extended
      logic [umi_cw-1:0] data;
   } umi_fields_t;

endpackage

/* verilog/umi_cfg_pkg.sv */
package umi_cfg_pkg;

   // Queue depths in packets
   localparam int unsigned hi_depth = 4;                // Posted writes and responses
   localparam int unsigned lo_depth = 4;                // Requests

   // Dropped command counter
   localparam int unsigned drop_cw = 8;                 // Saturates at all ones

endpackage

/* verilog/umi_if.sv */
`timescale 1ns/100ps

// One UMI packet channel, valid/ready handshake
interface umi_if import umi_pkg::*; ();

   logic     valid;                                     // Packet offered
   logic     ready;                                     // Sink can take it
   umi_pkt_t pkt;                                       // Held while valid and not ready

   // Producer side
   modport src (
      output valid,
      output pkt,
      input  ready
   );

   // Consumer side
   modport dst (
      input  valid,
      input  pkt,
      output ready
   );

endinterface

/* verilog/umi_decode.sv */
`timescale 1ns/100ps

// Opcode classification for the unpacker and egress
module umi_decode import umi_pkg::*; (
   input  logic [4:0] opcode,
   output logic       cmd_link,                         // Link request
   output logic       cmd_link_resp,                    // Link response
   output logic       cmd_error,                        // Error response
   output logic       cmd_response                      // High class
);

   logic is_link;
   logic is_link_resp;
   logic is_error;

   always_comb begin
      is_link      = 1'b0;
      is_link_resp = 1'b0;
      is_error     = 1'b0;
      case (opcode)
         umi_req_link:   is_link      = 1'b1;
         umi_resp_link:  is_link_resp = 1'b1;
         umi_resp_error: is_error     = 1'b1;
         default:        ;                              // Ordinary user layout
      endcase
   end

   assign cmd_link      = is_link;
   assign cmd_link_resp = is_link_resp;
   assign cmd_error     = is_error;

   // Odd opcodes are posted writes and responses
   assign cmd_response  = opcode[0];

endmodule

/* verilog/umi_unpack.sv */
`timescale 1ns/100ps

module umi_unpack import umi_pkg::*; (
   input  umi_pkt_t    pkt,
   output umi_fields_t fields,
   output logic        is_response                      // Opcode in high class
);

   logic [umi_cw-1:0] cmd;
   logic              cmd_link;
   logic              cmd_link_resp;
   logic              cmd_error;

   assign cmd = pkt.cmd;

   umi_decode u_decode (
      .opcode        (cmd[4:0]),
      .cmd_link      (cmd_link),
      .cmd_link_resp (cmd_link_resp),
      .cmd_error     (cmd_error),
      .cmd_response  (is_response)
   );

   assign fields.opcode = cmd[4:0];
   assign fields.size   = cmd[7:5];                     // Unused for error and link
   assign fields.len    = cmd[15:8];                    // Unused for atomic, error, link
   assign fields.prot   = cmd[17:16];
   assign fields.qos    = cmd[21:18];
   assign fields.eom    = cmd[22];
   assign fields.eof    = cmd[23];
   assign fields.ex     = cmd[24];
   assign fields.err    = {6'd0, cmd[23:22]};           // Meaningful for responses

   // Link kinds reuse most of the word as user bits
   assign fields.user = (cmd_link | cmd_link_resp) ? {cmd[31:25], cmd[23:8]} :
                        cmd_error                  ? {8'd0, cmd[31:25], cmd[15:8]} :
                                                     {16'd0, cmd[31:25]};

   assign fields.data = pkt.data;                       // Passed through

endmodule

/* verilog/umi_ingress.sv */
`timescale 1ns/100ps

module umi_ingress import umi_pkg::*, umi_cfg_pkg::*; (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               in_valid,
   output logic               in_ready,
   input  logic [umi_cw-1:0]  in_cmd,
   input  logic [umi_cw-1:0]  in_data,
   umi_if.src                 hi,
   umi_if.src                 lo,
   output logic [drop_cw-1:0] drop_count
);

   logic     slot_valid;                                // Skid slot occupied
   umi_pkt_t slot_pkt;                                  // Slot payload
   logic     slot_hi;                                   // Odd opcode, high class
   logic     slot_drain;                                // Slot empties this cycle
   logic     in_fire;                                   // Input handshake
   logic     in_invalid;                                // Opcode zero on input

   assign slot_hi    = slot_pkt.cmd[0];                 // Class from opcode bit 0
   assign slot_drain = slot_valid & (slot_hi ? hi.ready : lo.ready);
   assign in_ready   = ~slot_valid | slot_drain;        // Empty or emptying
   assign in_fire    = in_valid & in_ready;
   assign in_invalid = (in_cmd[4:0] == umi_req_invalid);

   // Steer the slot to one queue
   assign hi.valid = slot_valid & slot_hi;
   assign lo.valid = slot_valid & ~slot_hi;
   assign hi.pkt   = slot_pkt;
   assign lo.pkt   = slot_pkt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         slot_valid <= 1'b0;
      end else if (in_fire) begin
         slot_valid <= ~in_invalid;                     // Invalid commands never stored
      end else if (slot_drain) begin
         slot_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (in_fire && !in_invalid) begin
         slot_pkt <= '{cmd: in_cmd, data: in_data};     // Payload, no reset
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         drop_count <= '0;
      end else if (in_fire && in_invalid && (drop_count != {drop_cw{1'b1}})) begin
         drop_count <= drop_count + 1'b1;               // Saturating count
      end
   end

   // Nothing with opcode zero reaches a queue
   a_no_invalid_stored : assert property (@(posedge clk) disable iff (!rst_n)
      slot_valid |-> (slot_pkt.cmd[4:0] != umi_req_invalid));

endmodule

/* verilog/umi_fifo.sv */
`timescale 1ns/100ps

module umi_fifo import umi_pkg::*; #(
   parameter int unsigned depth = 4                     // Entries
) (
   input  logic clk,
   input  logic rst_n,
   umi_if.dst   wr,
   umi_if.src   rd
);

   localparam int unsigned aw = (depth > 1) ? $clog2(depth) : 1;  // Pointer width
   localparam int unsigned cw = $clog2(depth + 1);                // Count width
   localparam logic [aw-1:0] last_ptr = aw'(depth - 1);           // Wrap point
   localparam logic [cw-1:0] full_cnt = cw'(depth);

   umi_pkt_t      mem [depth];                          // Packet storage
   logic [aw-1:0] wr_ptr;
   logic [aw-1:0] rd_ptr;
   logic [cw-1:0] count;                                // Occupancy
   logic          push;
   logic          pop;

   assign wr.ready = (count != full_cnt);               // Low when full
   assign rd.valid = (count != '0);
   assign rd.pkt   = mem[rd_ptr];                       // Read straight from memory
   assign push     = wr.valid & wr.ready;
   assign pop      = rd.valid & rd.ready;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= wr.pkt;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
         if (pop) rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;                    // Idle or push with pop
         endcase
      end
   end

   a_count_bound : assert property (@(posedge clk) disable iff (!rst_n)
      count <= full_cnt);

   // Producer holds its packet until the queue takes it
   a_wr_hold : assert property (@(posedge clk) disable iff (!rst_n)
      (wr.valid && !wr.ready) |=> (wr.valid && $stable(wr.pkt)));

endmodule

/* verilog/umi_egress.sv */
`timescale 1ns/100ps

module umi_egress import umi_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   umi_if.dst          hi,
   umi_if.dst          lo,
   output logic        out_valid,
   input  logic        out_ready,
   output umi_fields_t out_fields
);

   umi_pkt_t    sel_pkt;                                // Winner of arbitration
   umi_fields_t sel_fields;
   logic        sel_resp;                               // Winner is high class
   logic        load;                                   // Output register can take
   logic        take_hi;
   logic        take_lo;

   assign load    = ~out_valid | out_ready;             // Empty or draining
   assign take_hi = load & hi.valid;
   assign take_lo = load & ~hi.valid & lo.valid;        // Only when hi is idle

   // Strict priority, one pop per load
   assign hi.ready = load;
   assign lo.ready = load & ~hi.valid;
   assign sel_pkt  = hi.valid ? hi.pkt : lo.pkt;

   umi_unpack u_unpack (
      .pkt         (sel_pkt),
      .fields      (sel_fields),
      .is_response (sel_resp)
   );

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (load) begin
         out_valid <= hi.valid | lo.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (take_hi || take_lo) begin
         out_fields <= sel_fields;                      // Registered unpacked fields
      end
   end

   // Output holds under back-pressure
   a_out_stable : assert property (@(posedge clk) disable iff (!rst_n)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_fields)));

   // Low queue only ever carries requests
   a_lo_request : assert property (@(posedge clk) disable iff (!rst_n)
      take_lo |-> !sel_resp);

endmodule

/* verilog/umi_rx_top.sv */
`timescale 1ns/100ps

module umi_rx_top import umi_pkg::*, umi_cfg_pkg::*; (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               in_valid,
   output logic               in_ready,
   input  logic [umi_cw-1:0]  in_cmd,
   input  logic [umi_cw-1:0]  in_data,
   output logic [drop_cw-1:0] drop_count,
   output logic               out_valid,
   input  logic               out_ready,
   output logic [4:0]         out_opcode,
   output logic [2:0]         out_size,
   output logic [7:0]         out_len,
   output logic [1:0]         out_prot,
   output logic [3:0]         out_qos,
   output logic               out_eom,
   output logic               out_eof,
   output logic               out_ex,
   output logic [22:0]        out_user,
   output logic [7:0]         out_err,
   output logic [umi_cw-1:0]  out_data
);

   umi_fields_t out_fields;

   umi_if if_hi_in ();                                  // Ingress to high queue
   umi_if if_lo_in ();                                  // Ingress to low queue
   umi_if if_hi_out ();                                 // High queue to egress
   umi_if if_lo_out ();                                 // Low queue to egress

   umi_ingress u_ingress (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .in_cmd     (in_cmd),
      .in_data    (in_data),
      .hi         (if_hi_in.src),
      .lo         (if_lo_in.src),
      .drop_count (drop_count)
   );

   umi_fifo #(.depth(hi_depth)) u_hi_q (
      .clk   (clk),
      .rst_n (rst_n),
      .wr    (if_hi_in.dst),
      .rd    (if_hi_out.src)
   );

   umi_fifo #(.depth(lo_depth)) u_lo_q (
      .clk   (clk),
      .rst_n (rst_n),
      .wr    (if_lo_in.dst),
      .rd    (if_lo_out.src)
   );

   umi_egress u_egress (
      .clk        (clk),
      .rst_n      (rst_n),
      .hi         (if_hi_out.dst),
      .lo         (if_lo_out.dst),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_fields (out_fields)
   );

   // Fields onto plain ports
   assign out_opcode = out_fields.opcode;
   assign out_size   = out_fields.size;
   assign out_len    = out_fields.len;
   assign out_prot   = out_fields.prot;
   assign out_qos    = out_fields.qos;
   assign out_eom    = out_fields.eom;
   assign out_eof    = out_fields.eof;
   assign out_ex     = out_fields.ex;
   assign out_user   = out_fields.user;
   assign out_err    = out_fields.err;
   assign out_data   = out_fields.data;

endmodule

/* verification/tb_clk_gen.sv */
`timescale 1ns/100ps

// Free running testbench clock
module tb_clk_gen #(
   parameter int period = 20                            // ns
) (
   output logic clk
);

   initial begin
      clk = 1'b0;                                       // Known level at time zero
      forever #(period / 2) clk = ~clk;
   end

endmodule

/* verification/umi_rx_tb.sv */
`timescale 1ns/100ps

module umi_rx_tb import umi_pkg::*, umi_cfg_pkg::*; ();

   logic               clk;
   logic               rst_n;
   logic               in_valid;
   logic               in_ready;
   logic [umi_cw-1:0]  in_cmd;
   logic [umi_cw-1:0]  in_data;
   logic [drop_cw-1:0] drop_count;
   logic               out_valid;
   logic               out_ready;
   logic [4:0]         out_opcode;
   logic [2:0]         out_size;
   logic [7:0]         out_len;
   logic [1:0]         out_prot;
   logic [3:0]         out_qos;
   logic               out_eom;
   logic               out_eof;
   logic               out_ex;
   logic [22:0]        out_user;
   logic [7:0]         out_err;
   logic [umi_cw-1:0]  out_data;

   logic [63:0] exp_hi[$];                              // Expected high class, {cmd, data}
   logic [63:0] exp_lo[$];                              // Expected low class
   bit          out_log[$];                             // Class bit of each output
   bit          ready_pat [1024];                       // out_ready pattern for the stream
   integer      seed;
   int          errors = 0;
   int          sent = 0;                               // Accepted packets, sets the watchdog
   int          drop_exp = 0;                           // Invalid commands accepted
   int          pat_idx = 0;
   bit          toggle_en = 1'b0;

   tb_clk_gen u_clk (.clk(clk));

   umi_rx_top u_dut (.*);

   task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   // User field layout by command kind
   function automatic logic [22:0] expected_user(input logic [31:0] cmd);
      if (cmd[4:0] == umi_req_link || cmd[4:0] == umi_resp_link)
         return {cmd[31:25], cmd[23:8]};
      else if (cmd[4:0] == umi_resp_error)
         return {8'd0, cmd[31:25], cmd[15:8]};
      return {16'd0, cmd[31:25]};
   endfunction

   function automatic logic [4:0] opcode_at(input int idx);
      case (idx % 10)
         0:       return umi_req_posted;
         1:       return umi_req_read;
         2:       return umi_resp_read;
         3:       return umi_req_write;
         4:       return umi_resp_write;
         5:       return umi_req_atomic;
         6:       return umi_resp_atomic;
         7:       return umi_req_link;
         8:       return umi_resp_error;
         default: return umi_resp_link;
      endcase
   endfunction

   function automatic logic [31:0] random_cmd(input logic [4:0] op);
      logic [31:0] r;
      r = $random(seed);
      return {r[31:5], op};                             // Random fields, fixed opcode
   endfunction

   task automatic check_fields(input logic [63:0] pkt);
      logic [31:0] cmd;
      cmd = pkt[63:32];
      check_value(out_opcode, cmd[4:0], "opcode");
      check_value(out_size, cmd[7:5], "size");
      check_value(out_len, cmd[15:8], "len");
      check_value(out_prot, cmd[17:16], "prot");
      check_value(out_qos, cmd[21:18], "qos");
      check_value(out_eom, cmd[22], "eom");
      check_value(out_eof, cmd[23], "eof");
      check_value(out_ex, cmd[24], "ex");
      check_value(out_user, expected_user(cmd), "user");
      check_value(out_err, {6'd0, cmd[23:22]}, "err");
      check_value(out_data, pkt[31:0], "data");
   endtask

   // Reference model, sorts accepted packets by class
   task automatic record_accept();
      sent++;
      if (in_cmd[4:0] == umi_req_invalid) drop_exp++;
      else if (in_cmd[0]) exp_hi.push_back({in_cmd, in_data});
      else exp_lo.push_back({in_cmd, in_data});
   endtask

   task automatic offer_cmd(input logic [31:0] cmd, input logic [31:0] data,
                            input int max_wait, output bit accepted);
      int waited;
      @(negedge clk);
      in_valid = 1'b1;
      in_cmd   = cmd;
      in_data  = data;
      accepted = 1'b0;
      waited   = 0;
      while (!accepted && waited < max_wait) begin
         @(posedge clk);
         waited++;
         accepted = in_ready;                           // Handshake at this edge
      end
      if (accepted) record_accept();
   endtask

   task automatic send_cmd(input logic [31:0] cmd, input logic [31:0] data);
      bit ok;
      offer_cmd(cmd, data, 1000, ok);
      if (!ok) begin
         errors++;
         $display("Input handshake never completed at %0t ns", $time);
      end
   endtask

   task automatic idle_input();
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_hi.size() != 0 || exp_lo.size() != 0) @(posedge clk);
      repeat (2) @(negedge clk);                        // Output register empties
   endtask

   // Output side checker
   always @(posedge clk) begin : monitor
      logic [63:0] exp_pkt;
      if (rst_n && out_valid && out_ready) begin
         out_log.push_back(out_opcode[0]);
         if (out_opcode[0] && exp_hi.size() != 0) begin
            exp_pkt = exp_hi.pop_front();
            check_fields(exp_pkt);
         end else if (!out_opcode[0] && exp_lo.size() != 0) begin
            exp_pkt = exp_lo.pop_front();
            check_fields(exp_pkt);
         end else begin
            errors++;
            $display("Unexpected packet on the output at %0t ns, opcode %0d", $time, out_opcode);
         end
      end
   end

   always @(negedge clk) begin
      if (toggle_en) begin
         out_ready = ready_pat[pat_idx % 1024];         // Random back-pressure
         pat_idx++;
      end
   end

   task automatic test_unpack();
      int i;
      @(negedge clk);
      out_ready = 1'b1;
      for (i = 0; i < 10; i++) send_cmd(random_cmd(opcode_at(i)), $random(seed));
      idle_input();
      wait_drain();
   endtask

   task automatic test_class_order();
      int i;
      @(negedge clk);
      out_ready = 1'b0;
      out_log.delete();
      send_cmd(random_cmd(umi_resp_write), $random(seed));   // Occupies the output register
      for (i = 0; i < 3; i++) send_cmd(random_cmd(opcode_at(2 * i + 1)), $random(seed));
      for (i = 0; i < 3; i++) send_cmd(random_cmd(opcode_at(2 * i + 2)), $random(seed));
      idle_input();
      repeat (4) @(negedge clk);                        // Slot settles into the queues
      out_ready = 1'b1;
      wait_drain();
      check_value(out_log.size(), 7, "outputs in class order test");
      for (i = 0; i < 7 && i < out_log.size(); i++)
         check_value(out_log[i], (i < 4), "class of output in order");
   endtask

   task automatic test_invalid_drop();
      int i;
      for (i = 0; i < 12; i++) begin
         if (i % 3 == 1) send_cmd(random_cmd(opcode_at(i)), $random(seed));
         else send_cmd(random_cmd(umi_req_invalid), $random(seed));
      end
      idle_input();
      wait_drain();
      check_value(drop_count, drop_exp, "drop_count");
   endtask

   task automatic test_backpressure();
      int accepted;
      int i;
      bit ok;
      @(negedge clk);
      out_ready = 1'b0;
      accepted  = 0;
      ok        = 1'b1;
      for (i = 0; i < 16 && ok; i++) begin
         offer_cmd(random_cmd(umi_resp_read), $random(seed), 8, ok);
         if (ok) accepted++;
      end
      check_value(accepted, hi_depth + 2, "packets accepted while stalled");
      @(negedge clk);
      out_ready = 1'b1;
      if (!ok) begin
         do @(posedge clk); while (!in_ready);          // Pending packet goes in
         record_accept();
      end
      idle_input();
      wait_drain();
   endtask

   task automatic test_random_stream();
      int         i;
      logic [4:0] op;
      for (i = 0; i < 1024; i++) ready_pat[i] = 1'($random(seed));
      @(posedge clk);
      toggle_en = 1'b1;
      for (i = 0; i < 200; i++) begin
         op = (($random(seed) & 15) == 0) ? umi_req_invalid :
                                            opcode_at($unsigned($random(seed)) % 10);
         send_cmd(random_cmd(op), $random(seed));
      end
      idle_input();
      @(posedge clk);
      toggle_en = 1'b0;
      @(negedge clk);
      out_ready = 1'b1;
      wait_drain();
      check_value(drop_count, drop_exp, "drop_count after stream");
      check_value(out_valid, 1'b0, "out_valid after drain");
   endtask

   initial begin
      seed      = 16;
      rst_n     = 1'b0;
      in_valid  = 1'b0;
      in_cmd    = '0;
      in_data   = '0;
      out_ready = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      check_value(in_ready, 1'b1, "in_ready after reset");
      check_value(out_valid, 1'b0, "out_valid after reset");
      check_value(drop_count, 0, "drop_count after reset");
      test_unpack();
      test_class_order();
      test_invalid_drop();
      test_backpressure();
      test_random_stream();
      $display("Summary: %0d errors, %0d packets accepted, %0d dropped", errors, sent, drop_exp);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   // Limit grows with the traffic sent
   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles <= 200 * sent + 1000) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles with %0d packets accepted", cycles, sent);
      $display("Checks failed");
      $finish;
   end

endmodule

/* flist.f */
verilog/umi_pkg.sv
verilog/umi_cfg_pkg.sv
verilog/umi_if.sv
verilog/umi_decode.sv
verilog/umi_unpack.sv
verilog/umi_ingress.sv
verilog/umi_fifo.sv
verilog/umi_egress.sv
verilog/umi_rx_top.sv
verification/tb_clk_gen.sv
verification/umi_rx_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the UMI receive path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module umi_rx_tb --Mdir obj_dir -o umi_rx_sim -f flist.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/umi_rx_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
